// File: mont_exp.f
common/mont_pkg.sv
mont_mul/mont_mul.sv
verilog/operand_bank.sv
verilog/exp_ctrl.sv
verilog/mont_exp_top.sv
test/mont_exp_sva.sv
test/mont_exp_tb.sv

// File: run.sh
#!/bin/sh
# compile the exponentiator testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f mont_exp.f \
	--top-module mont_exp_tb \
	-Mdir obj_dir -o mont_exp_sim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/mont_exp_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0

// File: test/mont_exp_tb.sv
/* exponentiator testbench, reference model, compare task and directed
   tests for reset, edge exponents, random jobs and start during busy */
`timescale 1ns/1ps

module mont_exp_tb;

	localparam int wait_limit = 20000; // about three jobs worth of cycles

	logic clk, reset, start;
	mont_pkg::word_t n0_prime;
	mont_pkg::load_word_t load;
	logic busy, res_valid;
	mont_pkg::word_t res_word;
	integer seed; // $random state

	mont_exp_top UUT (
		.clk(clk), .reset(reset), .start(start), .n0_prime(n0_prime), .load(load),
		.busy(busy), .res_valid(res_valid), .res_word(res_word)
	);

	always #10 clk = ~clk; // 20 ns period

	// -n^-1 mod 2^16 by newton iteration
	function automatic mont_pkg::word_t neg_inverse_word(input mont_pkg::word_t nw);
		mont_pkg::word_t x;
		x = nw; // right to 3 bits for odd n
		for (int k = 0; k < 4; k++)
			x = x * (16'd2 - nw * x);
		return -x;
	endfunction

	function automatic logic [63:0] r_squared_mod(input logic [63:0] n);
		logic [127:0] r_mod;
		r_mod = {64'd1, 64'd0} % {64'd0, n}; // 2^64 mod n
		r_mod = (r_mod * r_mod) % {64'd0, n};
		return r_mod[63:0];
	endfunction

	function automatic logic [63:0] mod_pow(input logic [63:0] m, e, n);
		logic [127:0] acc, base;
		acc = 128'd1 % {64'd0, n};
		base = {64'd0, m} % {64'd0, n};
		for (int k = 0; k < 64; k++) begin // square and multiply from the lsb
			if (e[k])
				acc = (acc * base) % {64'd0, n};
			base = (base * base) % {64'd0, n};
		end
		return acc[63:0];
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [63:0] got, exp);
		if (got !== exp)
			fail_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic load_job(input logic [63:0] n, m, e, t, input mont_pkg::word_t n0p);
		mont_pkg::load_word_t lw;
		@(posedge clk);
		start <= 1'b1;
		n0_prime <= n0p;
		for (int w = 0; w < mont_pkg::num_words; w++) begin // lsw first
			@(posedge clk);
			start <= 1'b0;
			lw.m = m[16*w +: 16];
			lw.e = e[16*w +: 16];
			lw.n = n[16*w +: 16];
			lw.t = t[16*w +: 16];
			load <= lw;
		end
		@(posedge clk);
		load <= '0;
		@(negedge clk);
		compare("busy", 64'(busy), 64'd1);
	endtask

	task automatic collect_result(output logic [63:0] got);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (!res_valid) begin
			if (cnt >= wait_limit)
				fail_run("timed out waiting for res_valid");
			@(negedge clk);
			cnt++;
		end
		for (int w = 0; w < mont_pkg::num_words; w++) begin
			compare("res_valid", 64'(res_valid), 64'd1);
			got[16*w +: 16] = res_word;
			@(negedge clk);
		end
		compare("res_valid", 64'(res_valid), 64'd0); // burst over
		cnt = 0;
		while (busy) begin
			if (cnt >= wait_limit)
				fail_run("timed out waiting for busy to fall");
			@(negedge clk);
			cnt++;
		end
	endtask

	task automatic run_job(input logic [63:0] n, m, e, expected);
		logic [63:0] got;
		load_job(n, m, e, r_squared_mod(n), neg_inverse_word(n[15:0]));
		collect_result(got);
		for (int w = 0; w < mont_pkg::num_words; w++)
			compare($sformatf("res_word[%0d]", w), 64'(got[16*w +: 16]),
				64'(expected[16*w +: 16]));
	endtask

	task automatic idle_after_reset();
		repeat (10) begin // outputs stay quiet without start
			@(negedge clk);
			compare("busy", 64'(busy), 64'd0);
			compare("res_valid", 64'(res_valid), 64'd0);
			compare("res_word", 64'(res_word), 64'd0);
		end
	endtask

	task automatic edge_exponents();
		logic [63:0] n, m;
		logic [127:0] sq;
		n = 64'h2B7E_1516_28AE_D2A7;
		m = 64'h0123_4567_89AB_CDEF;
		sq = ({64'd0, m} * {64'd0, m}) % {64'd0, n};
		run_job(n, m, 64'd0, 64'd1); // empty product
		run_job(n, m, 64'd1, m);
		run_job(n, m, 64'd2, sq[63:0]);
	endtask

	task automatic full_exponent_job();
		logic [63:0] n, m, e;
		n = 64'h3FFF_FFFF_FFFF_FFC5; // just under r/4
		m = 64'h1234_5678_9ABC_DEF1;
		e = 64'hC3A5_0F1E_8D27_B469; // no zero word
		run_job(n, m, e, mod_pow(m, e, n));
	endtask

	task automatic random_jobs();
		logic [31:0] r0, r1;
		logic [63:0] n, m, e;
		for (int k = 0; k < 8; k++) begin
			r0 = $random(seed);
			r1 = $random(seed);
			n = ({r0, r1} & 64'h3FFF_FFFF_FFFF_FFFF) | 64'd1; // odd with top bits clear
			r0 = $random(seed);
			r1 = $random(seed);
			m = {r0, r1} % n;
			if (m == 64'd0)
				m = 64'd1;
			r0 = $random(seed);
			r1 = $random(seed);
			e = {r0, r1};
			run_job(n, m, e, mod_pow(m, e, n));
		end
	endtask

	task automatic start_during_busy();
		logic [63:0] n, m, e, got;
		n = 64'h1F3D_5B79_9786_A4C3;
		m = 64'h0A1B_2C3D_4E5F_6071;
		e = 64'h8000_0001_7FFE_0003;
		load_job(n, m, e, r_squared_mod(n), neg_inverse_word(n[15:0]));
		repeat (20) @(posedge clk);
		start <= 1'b1; // should be dropped
		n0_prime <= 16'hDEAD;
		load <= '1;
		@(posedge clk);
		start <= 1'b0;
		load <= '0;
		collect_result(got);
		compare("result during ignored start", got, mod_pow(m, e, n));
		e = 64'h0000_FFFF_0000_1235; // next job straight after busy
		run_job(n, m, e, mod_pow(m, e, n));
	endtask

	initial begin
		seed = 48;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		n0_prime = '0;
		load = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		idle_after_reset();
		edge_exponents();
		full_exponent_job();
		random_jobs();
		start_during_busy();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: test/mont_exp_sva.sv
/* protocol assertions for the exponentiator top, bound into mont_exp_top */
`timescale 1ns/1ps

module mont_exp_sva (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic res_valid
);

	int run_len; // earlier consecutive res_valid cycles

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			run_len <= 0;
		else if (res_valid)
			run_len <= run_len + 1;
		else
			run_len <= 0;
	end

	valid_in_busy: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> busy) else $error("res_valid outside busy");

	burst_not_long: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> run_len < mont_pkg::num_words) else $error("res_valid burst too long");

	burst_not_short: assert property (@(posedge clk) disable iff (reset)
		$fell(res_valid) |-> run_len == mont_pkg::num_words) else $error("res_valid burst short");

	busy_after_start: assert property (@(posedge clk) disable iff (reset)
		start && !busy |=> busy) else $error("busy did not rise after start");

endmodule

bind mont_exp_top mont_exp_sva sva (
	.clk(clk), .reset(reset), .start(start), .busy(busy), .res_valid(res_valid)
);

// File: verilog/mont_exp_top.sv
/* modular exponentiator top, operand bank plus two montgomery engines
   under the exponent controller */
`timescale 1ns/1ps

module mont_exp_top (
	input logic clk,
	input logic reset,
	input logic start, // one cycle pulse
	input mont_pkg::word_t n0_prime, // -n^-1 mod 2^w, sampled with start
	input mont_pkg::load_word_t load, // operand words, lsw first
	output logic busy,
	output logic res_valid,
	output mont_pkg::word_t res_word
);

	logic operands_ready; // all words captured
	mont_pkg::bignum_t m_val, e_val, n_val, t_val;
	mont_pkg::word_t n0p_val;
	logic result_ready; // final product strobe
	mont_pkg::bignum_t result;

	logic a_start, b_start;
	mont_pkg::mont_req_t a_req, b_req;
	logic a_done, b_done;
	mont_pkg::bignum_t a_product, b_product;

	operand_bank bank (
		.clk(clk), .reset(reset),
		.start(start), .n0_prime(n0_prime), .load(load),
		.operands_ready(operands_ready),
		.m_val(m_val), .e_val(e_val), .n_val(n_val), .t_val(t_val),
		.n0p_val(n0p_val),
		.result_ready(result_ready), .result(result),
		.busy(busy), .res_valid(res_valid), .res_word(res_word)
	);

	mont_mul mul_a ( // c_bar products
		.clk(clk), .reset(reset),
		.start(a_start), .req(a_req), .n(n_val), .n0_prime(n0p_val),
		.done(a_done), .product(a_product)
	);

	mont_mul mul_b ( // m_bar squarings
		.clk(clk), .reset(reset),
		.start(b_start), .req(b_req), .n(n_val), .n0_prime(n0p_val),
		.done(b_done), .product(b_product)
	);

	exp_ctrl ctrl (
		.clk(clk), .reset(reset),
		.operands_ready(operands_ready),
		.m_val(m_val), .e_val(e_val), .t_val(t_val),
		.a_start(a_start), .b_start(b_start),
		.a_req(a_req), .b_req(b_req),
		.a_done(a_done), .b_done(b_done),
		.a_product(a_product), .b_product(b_product),
		.result_ready(result_ready), .result(result)
	);

endmodule

// File: verilog/exp_ctrl.sv
/* right-to-left exponent sequencer, mul_b squares m_bar every bit while
   mul_a folds m_bar into c_bar on set bits */
`timescale 1ns/1ps

module exp_ctrl (
	input logic clk,
	input logic reset,
	input logic operands_ready,
	input mont_pkg::bignum_t m_val,
	input mont_pkg::bignum_t e_val,
	input mont_pkg::bignum_t t_val,
	output logic a_start,
	output logic b_start,
	output mont_pkg::mont_req_t a_req,
	output mont_pkg::mont_req_t b_req,
	input logic a_done,
	input logic b_done,
	input mont_pkg::bignum_t a_product,
	input mont_pkg::bignum_t b_product,
	output logic result_ready, // one cycle in emit
	output mont_pkg::bignum_t result
);

	mont_pkg::exp_phase_t phase;
	mont_pkg::bit_idx_t bit_idx; // bit last issued
	mont_pkg::bit_idx_t nxt_idx;
	logic a_pend, b_pend; // engine result outstanding
	logic [mont_pkg::exp_bits-1:0] e_flat;
	mont_pkg::bignum_t c_bar, m_bar;
	logic clear; // both engines idle, results stored
	logic go_first, step_go, final_go, bit_go, e_bit;

	assign e_flat = e_val;
	assign clear = !a_pend && !b_pend;
	assign go_first = (phase == mont_pkg::idle) && operands_ready;
	assign step_go = clear && (phase == mont_pkg::to_mont || phase == mont_pkg::bit_step);
	assign final_go = step_go && (phase == mont_pkg::bit_step) && (bit_idx == mont_pkg::last_bit);
	assign bit_go = step_go && !final_go;
	assign nxt_idx = (phase == mont_pkg::to_mont) ? '0 : bit_idx + 1'b1;
	assign e_bit = e_flat[nxt_idx];
	assign result_ready = (phase == mont_pkg::emit);
	assign result = c_bar; // plain form after from_mont

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= mont_pkg::idle;
			bit_idx <= '0;
			a_pend <= 1'b0;
			b_pend <= 1'b0;
			a_start <= 1'b0;
			b_start <= 1'b0;
		end else begin
			a_start <= go_first || (bit_go && e_bit) || final_go;
			b_start <= go_first || bit_go;
			if (go_first || (bit_go && e_bit) || final_go)
				a_pend <= 1'b1;
			else if (a_done)
				a_pend <= 1'b0;
			if (go_first || bit_go)
				b_pend <= 1'b1;
			else if (b_done)
				b_pend <= 1'b0;
			if (bit_go)
				bit_idx <= nxt_idx;
			case (phase)
				mont_pkg::idle: if (go_first) phase <= mont_pkg::to_mont;
				mont_pkg::to_mont: if (clear) phase <= mont_pkg::bit_step;
				mont_pkg::bit_step: if (final_go) phase <= mont_pkg::from_mont;
				mont_pkg::from_mont: if (clear) phase <= mont_pkg::emit;
				default: phase <= mont_pkg::idle; // emit lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (a_done)
			c_bar <= a_product;
		if (b_done)
			m_bar <= b_product;
		if (go_first) begin
			a_req.a <= mont_pkg::bignum_t'(1); // monpro(1, r^2) = r mod n
			a_req.b <= t_val;
			b_req.a <= m_val; // m * r mod n
			b_req.b <= t_val;
		end else if (bit_go) begin
			a_req.a <= c_bar;
			a_req.b <= m_bar;
			b_req.a <= m_bar; // square for next bit
			b_req.b <= m_bar;
		end else if (final_go) begin
			a_req.a <= c_bar;
			a_req.b <= mont_pkg::bignum_t'(1); // strip r factor
		end
	end

endmodule

// File: verilog/operand_bank.sv
/* serial operand capture and serial result streaming */
`timescale 1ns/1ps

module operand_bank (
	input logic clk,
	input logic reset,
	input logic start,
	input mont_pkg::word_t n0_prime,
	input mont_pkg::load_word_t load,
	output logic operands_ready, // one cycle, after last load word
	output mont_pkg::bignum_t m_val,
	output mont_pkg::bignum_t e_val,
	output mont_pkg::bignum_t n_val,
	output mont_pkg::bignum_t t_val,
	output mont_pkg::word_t n0p_val,
	input logic result_ready,
	input mont_pkg::bignum_t result,
	output logic busy,
	output logic res_valid,
	output mont_pkg::word_t res_word
);

	logic accept; // start taken only when idle
	logic loading; // load words arriving
	mont_pkg::idx_t load_cnt;
	mont_pkg::idx_t emit_cnt; // index of word on res_word
	mont_pkg::bignum_t res_hold;

	assign accept = start && !busy;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			loading <= 1'b0;
			load_cnt <= '0;
			operands_ready <= 1'b0;
			res_valid <= 1'b0;
			res_word <= '0;
			emit_cnt <= '0;
		end else begin
			operands_ready <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				loading <= 1'b1;
				load_cnt <= '0;
			end else if (loading) begin
				load_cnt <= load_cnt + 1'b1;
				if (load_cnt == mont_pkg::last_idx) begin // last word in this cycle
					loading <= 1'b0;
					operands_ready <= 1'b1;
				end
			end
			if (result_ready) begin
				res_valid <= 1'b1;
				res_word <= result[0]; // lsw straight through
				emit_cnt <= '0;
			end else if (res_valid) begin
				if (emit_cnt == mont_pkg::last_idx) begin
					res_valid <= 1'b0;
					res_word <= '0;
					busy <= 1'b0; // job over
				end else begin
					res_word <= res_hold[emit_cnt + 1'b1];
					emit_cnt <= emit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			n0p_val <= n0_prime;
		if (loading) begin // shift down, new word enters at top
			m_val <= {load.m, m_val[mont_pkg::num_words-1:1]};
			e_val <= {load.e, e_val[mont_pkg::num_words-1:1]};
			n_val <= {load.n, n_val[mont_pkg::num_words-1:1]};
			t_val <= {load.t, t_val[mont_pkg::num_words-1:1]};
		end
		if (result_ready)
			res_hold <= result;
	end

endmodule

// File: mont_mul/mont_mul.sv
/* word-serial montgomery product a*b*r^-1 mod n, one registered
   multiply-add step every two cycles, no final subtraction */
`timescale 1ns/1ps

module mont_mul (
	input logic clk,
	input logic reset,
	input logic start, // samples req, n, n0_prime
	input mont_pkg::mont_req_t req,
	input mont_pkg::bignum_t n,
	input mont_pkg::word_t n0_prime,
	output logic done, // one cycle, product valid
	output mont_pkg::bignum_t product
);

	typedef enum logic [2:0] {
		s_mac, // v += a[i] * b
		s_fold, // carry into v[s], v[s+1]
		s_red, // reduction factor from v[0]
		s_sub, // v = (v + q * n) >> w
		s_top, // carry into v[s-1]
		s_hi // v[s] = v[s+1] + carry
	} step_t;

	step_t step;
	logic active;
	logic half; // 0 drive multiply-add, 1 sample it
	mont_pkg::idx_t i, j; // outer and inner word
	logic last_j, last_i;

	mont_pkg::bignum_t a_r, b_r, n_r;
	mont_pkg::word_t n0p_r;
	logic [mont_pkg::num_words+1:0][mont_pkg::word_width-1:0] v; // two spare top words
	mont_pkg::word_t carry;
	mont_pkg::word_t q; // reduction factor
	mont_pkg::word_t x_r, y_r, z_r, cin_r; // multiply-add inputs
	logic [2*mont_pkg::word_width-1:0] mac; // x*y + z + cin never overflows
	mont_pkg::word_t sum, cout;

	assign mac = {mont_pkg::word_t'(0), x_r} * {mont_pkg::word_t'(0), y_r}
		+ {mont_pkg::word_t'(0), z_r} + {mont_pkg::word_t'(0), cin_r};
	assign sum = mac[mont_pkg::word_width-1:0];
	assign cout = mac[2*mont_pkg::word_width-1:mont_pkg::word_width];
	assign last_j = (j == mont_pkg::last_idx);
	assign last_i = (i == mont_pkg::last_idx);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			step <= s_mac;
			half <= 1'b0;
			i <= '0;
			j <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				active <= 1'b1;
				step <= s_mac;
				half <= 1'b0;
				i <= '0;
				j <= '0;
			end else if (active) begin
				half <= ~half;
				if (half) begin // step completes this cycle
					case (step)
						s_mac: begin
							j <= last_j ? '0 : j + 1'b1;
							if (last_j)
								step <= s_fold;
						end
						s_fold: step <= s_red;
						s_red: step <= s_sub;
						s_sub: begin
							j <= last_j ? '0 : j + 1'b1;
							if (last_j)
								step <= s_top;
						end
						s_top: step <= s_hi;
						default: begin // s_hi, end of outer pass
							step <= s_mac;
							i <= i + 1'b1;
							if (last_i) begin
								active <= 1'b0;
								done <= 1'b1;
							end
						end
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			a_r <= req.a;
			b_r <= req.b;
			n_r <= n;
			n0p_r <= n0_prime;
			v <= '0;
		end else if (active && !half) begin // present operands
			case (step)
				s_mac: begin
					x_r <= a_r[i];
					y_r <= b_r[j];
					z_r <= v[j];
					cin_r <= (j == '0) ? '0 : carry; // fresh chain each pass
				end
				s_red: begin
					x_r <= v[0];
					y_r <= n0p_r;
					z_r <= '0;
					cin_r <= '0;
				end
				s_sub: begin
					x_r <= q;
					y_r <= n_r[j];
					z_r <= v[j];
					cin_r <= (j == '0) ? '0 : carry;
				end
				default: begin // carry folds, plain add
					x_r <= '0;
					y_r <= '0;
					z_r <= (step == s_hi) ? v[mont_pkg::num_words+1] : v[mont_pkg::num_words];
					cin_r <= carry;
				end
			endcase
		end else if (active) begin // collect sum and carry
			case (step)
				s_mac: begin
					v[j] <= sum;
					carry <= cout;
				end
				s_fold: begin
					v[mont_pkg::num_words] <= sum;
					v[mont_pkg::num_words+1] <= cout;
				end
				s_red: q <= sum; // low word only, mod 2^w
				s_sub: begin
					carry <= cout;
					if (j != '0) // word 0 is zero by construction, dropped
						v[j - 1'b1] <= sum;
				end
				s_top: begin
					v[mont_pkg::num_words-1] <= sum;
					carry <= cout;
				end
				default: begin
					v[mont_pkg::num_words] <= sum;
					if (last_i)
						product <= v[mont_pkg::num_words-1:0]; // low words already final
				end
			endcase
		end
	end

endmodule

// File: common/mont_pkg.sv
/* word and operand sizes, index types, load and engine request structs,
   exponent controller phases */
package mont_pkg;

	localparam int word_width = 16; // bits per datapath word
	localparam int num_words = 4; // words per operand
	localparam int exp_bits = word_width * num_words; // exponent bits swept
	localparam int idx_width = $clog2(num_words); // word index width

	typedef logic [word_width-1:0] word_t;
	typedef logic [num_words-1:0][word_width-1:0] bignum_t; // word 0 least significant
	typedef logic [idx_width-1:0] idx_t; // word counter
	typedef logic [$clog2(exp_bits)-1:0] bit_idx_t; // exponent bit counter

	localparam idx_t last_idx = idx_t'(num_words - 1); // top word index
	localparam bit_idx_t last_bit = bit_idx_t'(exp_bits - 1); // exponent msb

	// one word of every operand, presented together per load cycle
	typedef struct packed {
		word_t m; // message
		word_t e; // exponent
		word_t n; // odd modulus
		word_t t; // r^2 mod n
	} load_word_t;

	// factors for one montgomery product a * b * r^-1 mod n
	typedef struct packed {
		bignum_t a;
		bignum_t b;
	} mont_req_t;

	typedef enum logic [2:0] {
		idle, // waiting for operands
		to_mont, // c_bar and m_bar into montgomery form
		bit_step, // one exponent bit per pass
		from_mont, // c_bar back out of montgomery form
		emit // hand result to the bank
	} exp_phase_t;

endpackage
